// ==== rtl/conv_macros.svh ====
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// Data widths
`define PXL_W   8
`define WGT_W   8
`define BIAS_W  16
`define ACC_W   20
`define RES_W   16

// Kernel and frame geometry
`define KERNEL  3
`define IMG_W   16
`define IMG_H   8
`define COL_W   4
`define ROW_W   3

// Wishbone port and register map
`define WB_AW    4
`define WB_DW    16
`define REG_W0   0
`define REG_W8   8
`define REG_BIAS 9
`define REG_OP   10

`endif

// ==== rtl/conv_pkg.sv ====
`include "conv_macros.svh"

package conv_pkg;

	////////////////////
	// Operation codes

	// Bit 0 of the op register
	typedef enum logic {
		op_linear = 1'b0,
		op_relu   = 1'b1
	} conv_op_e;

	////////////////////
	// Window generator state

	typedef enum logic {
		win_fill = 1'b0,
		win_run  = 1'b1
	} conv_win_state_e;

	////////////////////
	// Result word

	typedef logic signed [`RES_W-1:0] conv_result_t;

endpackage

// ==== rtl/conv_if.sv ====
`timescale 1ns/10ps
`include "conv_macros.svh"

// One 3x3 window with p0 at the top row and left column
interface conv_window_if;
	logic              win_valid;
	logic [`PXL_W-1:0] p0, p1, p2;
	logic [`PXL_W-1:0] p3, p4, p5;
	logic [`PXL_W-1:0] p6, p7, p8;

	modport src (
		output win_valid, p0, p1, p2, p3, p4, p5, p6, p7, p8
	);
	modport dst (
		input  win_valid, p0, p1, p2, p3, p4, p5, p6, p7, p8
	);
endinterface

// Held coefficient levels with weights in the same order as the pixels
interface conv_coef_if;
	logic signed [`WGT_W-1:0]  w0, w1, w2;
	logic signed [`WGT_W-1:0]  w3, w4, w5;
	logic signed [`WGT_W-1:0]  w6, w7, w8;
	logic signed [`BIAS_W-1:0] bias;
	conv_pkg::conv_op_e        op;

	modport src (
		output w0, w1, w2, w3, w4, w5, w6, w7, w8, bias, op
	);
	modport dst (
		input  w0, w1, w2, w3, w4, w5, w6, w7, w8, bias, op
	);
endinterface

// ==== rtl/conv_window_gen.sv ====
`timescale 1ns/10ps
`include "conv_macros.svh"

module conv_window_gen (
	input  logic              clk,
	input  logic              reset,
	input  logic              pxl_valid,
	input  logic [`PXL_W-1:0] pxl_in,
	conv_window_if.src        win
);

	// Row r-1 and row r-2 of the frame
	logic [`PXL_W-1:0] line_a [`IMG_W];
	logic [`PXL_W-1:0] line_b [`IMG_W];

	// taps[row][col] with row 0 and col 0 oldest
	logic [`PXL_W-1:0] taps [`KERNEL][`KERNEL];

	logic [`COL_W-1:0]         col;
	logic [`ROW_W-1:0]         row;
	conv_pkg::conv_win_state_e state;
	logic                      col_last;
	logic                      row_last;
	logic                      closes;

	assign col_last = (col == (`IMG_W - 1));
	assign row_last = (row == (`IMG_H - 1));

	// Pixel completes an interior window
	assign closes = pxl_valid && (state == conv_pkg::win_run) && (col >= (`KERNEL - 1));

	////////////////////
	// Position counters

	always_ff @(posedge clk) begin
		if (reset) begin
			col   <= '0;
			row   <= '0;
			state <= conv_pkg::win_fill;
		end else if (pxl_valid) begin
			if (col_last) begin
				col <= '0;
				if (row_last) begin
					row   <= '0;
					state <= conv_pkg::win_fill;
				end else begin
					row <= row + 1'b1;
					// Third row about to start
					if (row == (`KERNEL - 2))
						state <= conv_pkg::win_run;
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	////////////////////
	// Line buffers and window taps

	always_ff @(posedge clk) begin
		if (pxl_valid) begin
			line_b[col] <= line_a[col];
			line_a[col] <= pxl_in;
			for (int r = 0; r < `KERNEL; r++) begin
				for (int c = 0; c < `KERNEL - 1; c++) begin
					taps[r][c] <= taps[r][c + 1];
				end
			end
			// Newest column enters on the right
			taps[0][`KERNEL - 1] <= line_b[col];
			taps[1][`KERNEL - 1] <= line_a[col];
			taps[2][`KERNEL - 1] <= pxl_in;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			win.win_valid <= 1'b0;
		else
			win.win_valid <= closes;
	end

	assign win.p0 = taps[0][0];
	assign win.p1 = taps[0][1];
	assign win.p2 = taps[0][2];
	assign win.p3 = taps[1][0];
	assign win.p4 = taps[1][1];
	assign win.p5 = taps[1][2];
	assign win.p6 = taps[2][0];
	assign win.p7 = taps[2][1];
	assign win.p8 = taps[2][2];

endmodule

// ==== rtl/conv_coef_regs.sv ====
`timescale 1ns/10ps
`include "conv_macros.svh"

module conv_coef_regs (
	input  logic              clk,
	input  logic              reset,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [`WB_AW-1:0] wb_adr,
	input  logic [`WB_DW-1:0] wb_dat_w,
	output logic [`WB_DW-1:0] wb_dat_r,
	output logic              wb_ack,
	conv_coef_if.src          coef
);

	logic signed [`WGT_W-1:0]  wgt [`KERNEL * `KERNEL];
	logic signed [`BIAS_W-1:0] bias;
	conv_pkg::conv_op_e        op;
	logic                      req;
	logic [`WB_DW-1:0]         rd_data;

	// New request not yet acknowledged
	assign req = wb_cyc && wb_stb && !wb_ack;

	////////////////////
	// Bus handshake

	always_ff @(posedge clk) begin
		if (reset)
			wb_ack <= 1'b0;
		else
			wb_ack <= req;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `KERNEL * `KERNEL; i++) begin
				wgt[i] <= '0;
			end
			bias <= '0;
			op   <= conv_pkg::op_linear;
		end else if (req && wb_we) begin
			if (wb_adr <= `REG_W8)
				wgt[wb_adr] <= wb_dat_w[`WGT_W-1:0];
			else if (wb_adr == `REG_BIAS)
				bias <= wb_dat_w;
			else if (wb_adr == `REG_OP)
				op <= conv_pkg::conv_op_e'(wb_dat_w[0]);
		end
	end

	////////////////////
	// Read path

	always_comb begin
		rd_data = '0;
		if (wb_adr <= `REG_W8)
			rd_data = {{(`WB_DW - `WGT_W){wgt[wb_adr][`WGT_W-1]}}, wgt[wb_adr]};
		else if (wb_adr == `REG_BIAS)
			rd_data = bias;
		else if (wb_adr == `REG_OP)
			rd_data = {{(`WB_DW - 1){1'b0}}, op};
	end

	// Captured with the ack so it is stable while ack is high
	always_ff @(posedge clk) begin
		if (req)
			wb_dat_r <= rd_data;
	end

	assign coef.w0   = wgt[0];
	assign coef.w1   = wgt[1];
	assign coef.w2   = wgt[2];
	assign coef.w3   = wgt[3];
	assign coef.w4   = wgt[4];
	assign coef.w5   = wgt[5];
	assign coef.w6   = wgt[6];
	assign coef.w7   = wgt[7];
	assign coef.w8   = wgt[8];
	assign coef.bias = bias;
	assign coef.op   = op;

endmodule

// ==== rtl/conv_mac.sv ====
`timescale 1ns/10ps
`include "conv_macros.svh"

module conv_mac (
	input  logic                  clk,
	input  logic                  reset,
	conv_window_if.dst            win,
	conv_coef_if.dst              coef,
	output logic                  res_valid,
	output conv_pkg::conv_result_t res_out
);

	localparam int TAPS   = `KERNEL * `KERNEL;
	localparam int PROD_W = `PXL_W + `WGT_W + 1;
	localparam int SUM_W  = `ACC_W + 1;

	localparam logic signed [SUM_W-1:0] RES_MAX = 2 ** (`RES_W - 1) - 1;
	localparam logic signed [SUM_W-1:0] RES_MIN = -(2 ** (`RES_W - 1));

	logic [`PXL_W-1:0]        pix  [TAPS];
	logic signed [`WGT_W-1:0] wgt  [TAPS];
	logic signed [PROD_W-1:0] prod [TAPS];
	logic signed [`ACC_W-1:0] tree_sum;
	logic signed [`ACC_W-1:0] acc;
	logic signed [SUM_W-1:0]  biased;
	conv_pkg::conv_result_t   shaped;
	logic                     prod_valid;
	logic                     acc_valid;

	assign pix = '{win.p0, win.p1, win.p2, win.p3, win.p4, win.p5, win.p6, win.p7, win.p8};
	assign wgt = '{coef.w0, coef.w1, coef.w2, coef.w3, coef.w4,
	               coef.w5, coef.w6, coef.w7, coef.w8};

	////////////////////
	// Stage 1 products

	always_ff @(posedge clk) begin
		for (int i = 0; i < TAPS; i++) begin
			// Pixel is unsigned, so zero-extend before the signed multiply
			prod[i] <= $signed({1'b0, pix[i]}) * wgt[i];
		end
	end

	////////////////////
	// Stage 2 adder tree

	always_comb begin
		tree_sum = '0;
		for (int i = 0; i < TAPS; i++) begin
			tree_sum = tree_sum + prod[i];
		end
	end

	always_ff @(posedge clk) begin
		acc <= tree_sum;
	end

	////////////////////
	// Stage 3 bias, ReLU, clamp

	always_comb begin
		biased = acc + coef.bias;
		if (coef.op == conv_pkg::op_relu && biased < 0)
			shaped = '0;
		else if (biased > RES_MAX)
			shaped = RES_MAX[`RES_W-1:0];
		else if (biased < RES_MIN)
			shaped = RES_MIN[`RES_W-1:0];
		else
			shaped = biased[`RES_W-1:0];
	end

	always_ff @(posedge clk) begin
		res_out <= shaped;
	end

	// Valid travels alongside the data
	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid <= 1'b0;
			acc_valid  <= 1'b0;
			res_valid  <= 1'b0;
		end else begin
			prod_valid <= win.win_valid;
			acc_valid  <= prod_valid;
			res_valid  <= acc_valid;
		end
	end

endmodule

// ==== rtl/conv_3x3_top.sv ====
`timescale 1ns/10ps
`include "conv_macros.svh"

module conv_3x3_top (
	input  logic                   clk,
	input  logic                   reset,

	// Pixel stream
	input  logic                   pxl_valid,
	input  logic [`PXL_W-1:0]      pxl_in,

	// Wishbone classic slave
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  logic [`WB_AW-1:0]      wb_adr,
	input  logic [`WB_DW-1:0]      wb_dat_w,
	output logic [`WB_DW-1:0]      wb_dat_r,
	output logic                   wb_ack,

	// Results
	output logic                   res_valid,
	output conv_pkg::conv_result_t res_out
);

	conv_window_if win_if ();
	conv_coef_if   coef_if ();

	conv_window_gen window_gen_i (
		.clk       (clk),
		.reset     (reset),
		.pxl_valid (pxl_valid),
		.pxl_in    (pxl_in),
		.win       (win_if.src)
	);

	conv_coef_regs coef_regs_i (
		.clk       (clk),
		.reset     (reset),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.coef      (coef_if.src)
	);

	// One cycle of windowing plus three MAC stages
	conv_mac mac_i (
		.clk       (clk),
		.reset     (reset),
		.win       (win_if.dst),
		.coef      (coef_if.dst),
		.res_valid (res_valid),
		.res_out   (res_out)
	);

endmodule

// ==== testbench/conv_3x3_asserts.sv ====
`timescale 1ns/10ps

module conv_3x3_asserts (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic pxl_valid,
	input logic win_valid,
	input logic res_valid
);

	// Running count of failed assertions
	int assert_failures = 0;

	////////////////////
	// Wishbone handshake

	ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
		else begin
			$error("wb_ack stayed high for two cycles");
			assert_failures++;
		end

	ack_requested: assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else begin
			$error("wb_ack without a request in the cycle before");
			assert_failures++;
		end

	////////////////////
	// Result four cycles behind the closing pixel

	res_has_window: assert property (@(posedge clk) disable iff (reset)
		res_valid |-> $past(pxl_valid, 4) && $past(win_valid, 3))
		else begin
			$error("res_valid without a window closed by a pixel four cycles earlier");
			assert_failures++;
		end

	window_has_res: assert property (@(posedge clk) disable iff (reset)
		$past(win_valid, 3) |-> res_valid)
		else begin
			$error("window three cycles earlier gave no res_valid");
			assert_failures++;
		end

	quiet_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> !res_valid && !win_valid && !wb_ack)
		else begin
			$error("valid or ack high in the first cycle after reset");
			assert_failures++;
		end

endmodule

// ==== testbench/conv_3x3_checker.sv ====
`timescale 1ns/10ps

module conv_3x3_checker (
	input logic                   clk,
	input logic                   reset,
	input logic                   res_valid,
	input conv_pkg::conv_result_t res_out
);

	// Expected results and the cycle each one is due
	logic [15:0] exp_val [$];
	int unsigned exp_cyc [$];
	int unsigned cycle = 0;
	int          error_count = 0;
	int          match_count = 0;
	logic [15:0] head_val;
	int unsigned head_cyc;

	// Edge count as seen just after each rising edge
	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic expect_result(input logic [15:0] val, input int unsigned at_cycle);
		exp_val.push_back(val);
		exp_cyc.push_back(at_cycle);
	endtask

	task automatic note_failure(input string what);
		$display("%s", what);
		error_count++;
	endtask

	task automatic compare_reg(input int adr, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("ERROR wb_dat_r at address 0x%0h: expected 0x%04h, got 0x%04h",
				adr, exp, act);
			error_count++;
		end
	endtask

	task automatic drop_missing();
		note_failure($sformatf("%0d expected results never appeared on res_out",
			exp_val.size()));
		exp_val.delete();
		exp_cyc.delete();
	endtask

	////////////////////
	// Result comparison

	always @(posedge clk) begin
		if (!reset && res_valid) begin
			if (exp_val.size() == 0) begin
				note_failure($sformatf("res_valid high at cycle %0d with no window pending", cycle));
			end else begin
				head_val = exp_val.pop_front();
				head_cyc = exp_cyc.pop_front();
				if (res_out !== head_val) begin
					$display("ERROR res_out: expected 0x%04h, got 0x%04h", head_val, res_out);
					error_count++;
				end else if (cycle != head_cyc) begin
					note_failure($sformatf("Result arrived at cycle %0d but was due at cycle %0d",
						cycle, head_cyc));
				end else begin
					match_count++;
				end
			end
		end
	end

endmodule

// ==== testbench/conv_3x3_tb.sv ====
`timescale 1ns/10ps
`include "conv_macros.svh"

module conv_3x3_tb;

	localparam int WINDOWS = (`IMG_W - `KERNEL + 1) * (`IMG_H - `KERNEL + 1);

	logic                      clk, reset, pxl_valid;
	logic [`PXL_W-1:0]         pxl_in;
	logic                      wb_cyc, wb_stb, wb_we, wb_ack;
	logic [`WB_AW-1:0]         wb_adr;
	logic [`WB_DW-1:0]         wb_dat_w, wb_dat_r, rd;
	logic                      res_valid;
	conv_pkg::conv_result_t    res_out;

	// Reference model state
	logic [15:0]               lfsr;
	logic signed [`WGT_W-1:0]  w_model [9];
	logic signed [`BIAS_W-1:0] bias_model;
	logic                      op_model;
	logic [`PXL_W-1:0]         frame [`IMG_H][`IMG_W];
	int                        tests_run, tests_failed, err_base, res_base, assert_base;

	conv_3x3_top dut_i (.*);
	conv_3x3_checker checker_i (.clk, .reset, .res_valid, .res_out);

	bind conv_3x3_top conv_3x3_asserts asserts_i (.clk, .reset, .wb_cyc, .wb_stb, .wb_ack,
		.pxl_valid, .win_valid(win_if.win_valid), .res_valid);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		logic        b;
		v = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b)
				lfsr = lfsr ^ 16'hb400;
			v = {v[14:0], b};
		end
		return v;
	endfunction

	// Expected result of the window closed at (r, c)
	function automatic logic [15:0] window_result(input int r, input int c);
		int sum;
		sum = bias_model;
		for (int i = 0; i < `KERNEL; i++) begin
			for (int j = 0; j < `KERNEL; j++) begin
				sum += int'(frame[r - 2 + i][c - 2 + j]) * int'(w_model[3 * i + j]);
			end
		end
		if (op_model && sum < 0)
			sum = 0;
		else if (sum > 32767)
			sum = 32767;
		else if (sum < -32768)
			sum = -32768;
		return sum[15:0];
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	// One Wishbone classic cycle with the read data left in rd
	task automatic wb_access(input logic we, input int adr, input logic [15:0] wdat);
		int waited;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = `WB_AW'(adr);
		wb_dat_w = wdat;
		tick();
		while (!wb_ack && waited < 8) begin
			tick();
			waited++;
		end
		if (!wb_ack)
			checker_i.note_failure($sformatf("No wb_ack for address %0d", adr));
		rd = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		tick();
	endtask

	task automatic load_coefs();
		for (int i = 0; i < 9; i++)
			wb_access(1'b1, i, {8'h00, w_model[i]});
		wb_access(1'b1, `REG_BIAS, bias_model);
		wb_access(1'b1, `REG_OP, {15'd0, op_model});
	endtask

	task automatic random_coefs(input logic op);
		for (int i = 0; i < 9; i++)
			w_model[i] = take_bits(8);
		bias_model = take_bits(16);
		op_model = op;
		load_coefs();
	endtask

	// Full frame in raster order with optional idle cycles before each pixel
	task automatic send_frame(input logic gaps);
		int idle;
		for (int r = 0; r < `IMG_H; r++) begin
			for (int c = 0; c < `IMG_W; c++) begin
				idle = gaps ? int'(take_bits(2)) : 0;
				pxl_valid = 1'b0;
				repeat (idle)
					tick();
				pxl_valid = 1'b1;
				pxl_in = take_bits(8);
				frame[r][c] = pxl_in;
				if (r >= `KERNEL - 1 && c >= `KERNEL - 1)
					checker_i.expect_result(window_result(r, c), checker_i.cycle + 4);
				tick();
			end
		end
		pxl_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (checker_i.exp_val.size() != 0 && waited < 20) begin
			tick();
			waited++;
		end
		if (checker_i.exp_val.size() != 0)
			checker_i.drop_missing();
	endtask

	task automatic finish_test(input string name, input int n_results);
		int got;
		int errs;
		wait_drain();
		got = checker_i.match_count - res_base;
		if (got != n_results)
			checker_i.note_failure($sformatf("Test %s gave %0d good results instead of %0d",
				name, got, n_results));
		errs = (checker_i.error_count - err_base)
			+ (dut_i.asserts_i.assert_failures - assert_base);
		tests_run++;
		if (errs != 0)
			tests_failed++;
		$display("Test %s: %0d results, %0d errors", name, got, errs);
		err_base = checker_i.error_count;
		res_base = checker_i.match_count;
		assert_base = dut_i.asserts_i.assert_failures;
	endtask

	initial begin
		logic [15:0] wr_data [16];
		logic [15:0] exp_rd;
		lfsr = 16'd5;
		reset = 1'b1;
		pxl_valid = 1'b0;
		pxl_in = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		tests_run = 0;
		tests_failed = 0;
		err_base = 0;
		res_base = 0;
		assert_base = 0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		////////////////////
		// Register access including unmapped addresses
		for (int a = 0; a < 16; a++) begin
			wr_data[a] = take_bits(16);
			wb_access(1'b1, a, wr_data[a]);
		end
		for (int a = 0; a < 16; a++) begin
			wb_access(1'b0, a, '0);
			if (a <= `REG_W8)
				exp_rd = {{8{wr_data[a][7]}}, wr_data[a][7:0]};
			else if (a == `REG_BIAS)
				exp_rd = wr_data[a];
			else if (a == `REG_OP)
				exp_rd = {15'd0, wr_data[a][0]};
			else
				exp_rd = '0;
			checker_i.compare_reg(a, exp_rd, rd);
		end
		finish_test("register access", 0);

		random_coefs(conv_pkg::op_linear);
		send_frame(1'b0);
		finish_test("linear convolution", WINDOWS);

		////////////////////
		// Extreme weights and bias under both op codes
		for (int k = 0; k < 4; k++) begin
			for (int i = 0; i < 9; i++)
				w_model[i] = k[0] ? 8'h80 : 8'h7f;
			bias_model = k[0] ? 16'h8000 : 16'h7fff;
			op_model = k[1];
			load_coefs();
			send_frame(1'b0);
			wait_drain();
		end
		finish_test("relu and saturation", 4 * WINDOWS);

		random_coefs(take_bits(1) != 0);
		send_frame(1'b1);
		finish_test("stream gaps", WINDOWS);

		// Coefficient change while idle before two frames with no gap
		random_coefs(conv_pkg::op_linear);
		send_frame(1'b0);
		wait_drain();
		random_coefs(conv_pkg::op_relu);
		send_frame(1'b0);
		send_frame(1'b0);
		finish_test("back-to-back frames", 3 * WINDOWS);

		$display("Tests run %0d, tests failed %0d, failed checks %0d, %s %0d, good results %0d",
			tests_run, tests_failed, checker_i.error_count, "failed assertions",
			dut_i.asserts_i.assert_failures, checker_i.match_count);
		if (tests_failed == 0 && checker_i.error_count == 0
			&& dut_i.asserts_i.assert_failures == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== conv_3x3_top.f ====
+incdir+rtl
rtl/conv_pkg.sv
rtl/conv_if.sv
rtl/conv_window_gen.sv
rtl/conv_coef_regs.sv
rtl/conv_mac.sv
rtl/conv_3x3_top.sv
testbench/conv_3x3_asserts.sv
testbench/conv_3x3_checker.sv
testbench/conv_3x3_tb.sv
